// File: src.f
verilog/lsu_pkg.sv
verilog/lsu_lsc_ctl.sv
verilog/lsu_stbuf.sv
verilog/lsu_dccm_ctl.sv
verilog/lsu.sv
testbench/lsu_tb.sv

// File: Makefile
TOP = lsu_tb
LOG = sim.log

.PHONY: run build lint clean

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

build:
	verilator --binary --timing -sv -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

lint:
	verilator --lint-only --timing -sv -f src.f --top-module $(TOP)
	verilator --lint-only -sv verilog/lsu_pkg.sv verilog/lsu_lsc_ctl.sv \
		verilog/lsu_stbuf.sv verilog/lsu_dccm_ctl.sv verilog/lsu.sv --top-module lsu

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

   import lsu_pkg::*;

   typedef struct {
      string       name;
      bit          st;
      int          size;
      bit          uns;
      addr_t       rs1;
      logic [11:0] off;
      data_t       data;
      lsu_fault_e  fault;
      int          gap;
   } op_t;

   localparam int N_RANDOM = 200;

   logic           clk;
   logic           rst_n;
   lsu_pkt_t       lsu_p;
   data_t          rs1;
   data_t          rs2;
   logic [11:0]    offset;
   data_t          dccm_rd_data = '0;
   data_t          lsu_result_dc3;
   logic           lsu_load_valid_dc3;
   lsu_error_pkt_t lsu_error_pkt_dc3;
   logic           lsu_store_stall;
   logic           lsu_idle;
   logic           dccm_rden;
   logic           dccm_wren;
   dccm_addr_t     dccm_addr;
   data_t          dccm_wr_data;
   byteen_t        dccm_wr_byteen;

   data_t      dccm_mem [1<<DCCM_WORD_BITS];
   logic [7:0] shadow [1<<DCCM_BITS];
   bit         touched [1<<DCCM_WORD_BITS];
   op_t        op_table [$];

   // expected responses, in issue order
   string      exp_name_q [$];
   bit         exp_fault_q [$];
   data_t      exp_val_q [$];
   lsu_fault_e exp_cause_q [$];
   bit         exp_store_q [$];
   addr_t      exp_addr_q [$];
   int         exp_cyc_q [$];

   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          reads_seen = 0;
   int          writes_seen = 0;
   int          reads_exp = 0;
   int          writes_exp = 0;
   int          last_op_cyc = -10;
   logic [31:0] rng;

   lsu dut_i (
      .clk(clk), .rst_n(rst_n), .lsu_p(lsu_p), .exu_lsu_rs1_d(rs1), .exu_lsu_rs2_d(rs2),
      .dec_lsu_offset_d(offset), .lsu_result_dc3(lsu_result_dc3),
      .lsu_load_valid_dc3(lsu_load_valid_dc3), .lsu_error_pkt_dc3(lsu_error_pkt_dc3),
      .lsu_store_stall(lsu_store_stall), .lsu_idle(lsu_idle), .dccm_rden(dccm_rden),
      .dccm_wren(dccm_wren), .dccm_addr(dccm_addr), .dccm_wr_data(dccm_wr_data),
      .dccm_wr_byteen(dccm_wr_byteen), .dccm_rd_data(dccm_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // single-port dccm, read data one cycle after rden
   always @(posedge clk) begin
      if (dccm_wren) begin
         for (int b = 0; b < DCCM_BYTE_WIDTH; b++) begin
            if (dccm_wr_byteen[b]) dccm_mem[dccm_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];
         end
         writes_seen <= writes_seen + 1;
      end
      if (dccm_rden) begin
         dccm_rd_data <= dccm_mem[dccm_addr];
         reads_seen   <= reads_seen + 1;
      end
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic data_t fill_word(input int w);
      return (32'(w) * 32'h9E37_79B1) + 32'h1234_5678;
   endfunction

   function automatic lsu_fault_e fault_of(input addr_t a, input int size);
      if ((size == 1 && a[0]) || (size == 2 && a[1:0] != 2'b00)) return FAULT_MISALIGNED;
      if (a < DCCM_BASE || a >= DCCM_BASE + 32'h0001_0000) return FAULT_ACCESS;
      return FAULT_NONE;
   endfunction

   function automatic data_t load_expected(input addr_t a, input int size, input bit uns);
      data_t v;
      v = {shadow[{a[15:2], 2'd3}], shadow[{a[15:2], 2'd2}],
           shadow[{a[15:2], 2'd1}], shadow[{a[15:2], 2'd0}]};
      v = v >> {a[1:0], 3'b000};
      if (size == 0) v = uns ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
      else if (size == 1) v = uns ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
      return v;
   endfunction

   task automatic add_op(input string name, input bit st, input int size, input bit uns,
                         input addr_t base, input logic [11:0] off, input data_t data,
                         input lsu_fault_e fault, input int gap);
      op_t op;
      op.name  = name;
      op.st    = st;
      op.size  = size;
      op.uns   = uns;
      op.rs1   = base;
      op.off   = off;
      op.data  = data;
      op.fault = fault;
      op.gap   = gap;
      op_table.push_back(op);
   endtask

   task automatic build_table();
      add_op("ld_w",       0, 2, 0, DCCM_BASE + 32'h100, 12'h000, 0, FAULT_NONE, 1);
      add_op("ld_b_s",     0, 0, 0, DCCM_BASE + 32'h100, 12'h003, 0, FAULT_NONE, 0);
      add_op("ld_b_u",     0, 0, 1, DCCM_BASE + 32'h100, 12'h003, 0, FAULT_NONE, 0);
      add_op("ld_h_s",     0, 1, 0, DCCM_BASE + 32'h104, 12'h002, 0, FAULT_NONE, 2);
      add_op("ld_h_u",     0, 1, 1, DCCM_BASE + 32'h104, 12'h002, 0, FAULT_NONE, 0);
      add_op("st_w_fwd",   1, 2, 0, DCCM_BASE + 32'h200, 12'h000, 32'h8899_AABB,
             FAULT_NONE, 0);
      add_op("ld_w_fwd",   0, 2, 0, DCCM_BASE + 32'h200, 12'h000, 0, FAULT_NONE, 0);
      // byte store over the older word store
      add_op("st_b_part",  1, 0, 0, DCCM_BASE + 32'h200, 12'h001, 32'h0000_0055,
             FAULT_NONE, 0);
      add_op("ld_w_merge", 0, 2, 0, DCCM_BASE + 32'h200, 12'h000, 0, FAULT_NONE, 0);
      add_op("ld_b_merge", 0, 0, 0, DCCM_BASE + 32'h200, 12'h001, 0, FAULT_NONE, 0);
      add_op("ld_h_merge", 0, 1, 0, DCCM_BASE + 32'h200, 12'h002, 0, FAULT_NONE, 3);
      add_op("ld_h_mis",   0, 1, 0, DCCM_BASE + 32'h300, 12'h001, 0, FAULT_MISALIGNED, 0);
      add_op("st_w_mis",   1, 2, 0, DCCM_BASE + 32'h300, 12'h002, 32'hDEAD_BEEF,
             FAULT_MISALIGNED, 0);
      add_op("ld_w_mis",   0, 2, 0, DCCM_BASE + 32'h300, 12'h003, 0, FAULT_MISALIGNED, 1);
      add_op("ld_w_acc",   0, 2, 0, 32'h1000_0000, 12'h000, 0, FAULT_ACCESS, 0);
      add_op("st_b_acc",   1, 0, 0, DCCM_BASE + 32'h0001_0000, 12'h000, 32'h11,
             FAULT_ACCESS, 0);
      add_op("ld_w_below", 0, 2, 0, DCCM_BASE, 12'hFFC, 0, FAULT_ACCESS, 2);
      // store burst, then a long run of back-to-back loads
      for (int i = 0; i < 6; i++) begin
         add_op("st_burst", 1, 2, 0, DCCM_BASE + 32'h400, 12'(4 * i), 32'hC0DE_0000 + i,
                FAULT_NONE, 0);
      end
      for (int i = 0; i < 12; i++) begin
         add_op("ld_burst", 0, 2, 0, DCCM_BASE + 32'h400, 12'(4 * (i % 6)), 0,
                FAULT_NONE, 0);
      end
   endtask

   task automatic issue_op(input op_t op);
      addr_t a;
      int    nb;
      a  = op.rs1 + {{20{op.off[11]}}, op.off};
      nb = 1 << op.size;
      while (op.st && lsu_store_stall) begin
         lsu_p = '0;
         @(posedge clk);
         #1;
      end
      // stores not yet written are the entries plus the stores in dc1 and dc2
      check({op.name, " store_stall"}, 32'(writes_exp - writes_seen >= LSU_SB_DEPTH),
            32'(lsu_store_stall));
      check({op.name, " idle"}, 32'(cyc - last_op_cyc > 2 && writes_exp == writes_seen),
            32'(lsu_idle));
      lsu_p        = '0;
      lsu_p.valid  = 1'b1;
      lsu_p.load   = ~op.st;
      lsu_p.store  = op.st;
      lsu_p.by     = (op.size == 0);
      lsu_p.half   = (op.size == 1);
      lsu_p.word   = (op.size == 2);
      lsu_p.unsign = op.uns;
      rs1          = op.rs1;
      rs2          = op.data;
      offset       = op.off;
      last_op_cyc  = cyc;
      if (op.st) touched[a[15:2]] = 1'b1;
      if (op.fault != FAULT_NONE || !op.st) begin
         exp_name_q.push_back(op.name);
         exp_fault_q.push_back(op.fault != FAULT_NONE);
         exp_cause_q.push_back(op.fault);
         exp_store_q.push_back(op.st);
         exp_addr_q.push_back(a);
         exp_cyc_q.push_back(cyc);
         exp_val_q.push_back(op.fault == FAULT_NONE ? load_expected(a, op.size, op.uns) : 0);
         if (op.fault == FAULT_NONE) reads_exp++;
      end else begin
         writes_exp++;
         for (int i = 0; i < nb; i++) shadow[a[15:0] + 16'(i)] = op.data[8*i +: 8];
      end
      @(posedge clk);
      #1;
      lsu_p = '0;
      repeat (op.gap) begin
         @(posedge clk);
         #1;
      end
   endtask

   // registered outputs, sampled mid-cycle
   always @(negedge clk) begin : response_monitor
      string n;
      bit    f;
      if (rst_n && (lsu_load_valid_dc3 || lsu_error_pkt_dc3.exc_valid)) begin
         if (exp_name_q.size() == 0) begin
            $display("unexpected response from the DUT at cycle %0d", cyc);
            errors++;
         end else begin
            n = exp_name_q.pop_front();
            f = exp_fault_q.pop_front();
            check({n, " latency"}, 32'd3, 32'(cyc - exp_cyc_q.pop_front()));
            check({n, " exc_valid"}, 32'(f), 32'(lsu_error_pkt_dc3.exc_valid));
            check({n, " load_valid"}, 32'(!f), 32'(lsu_load_valid_dc3));
            if (f) begin
               check({n, " mscause"}, 32'(exp_cause_q.pop_front()),
                     32'(lsu_error_pkt_dc3.mscause));
               check({n, " is_store"}, 32'(exp_store_q.pop_front()),
                     32'(lsu_error_pkt_dc3.is_store));
               check({n, " addr"}, exp_addr_q.pop_front(), lsu_error_pkt_dc3.addr);
               void'(exp_val_q.pop_front());
            end else begin
               check({n, " data"}, exp_val_q.pop_front(), lsu_result_dc3);
               void'(exp_cause_q.pop_front());
               void'(exp_store_q.pop_front());
               void'(exp_addr_q.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      #1;
      limit = (op_table.size() + N_RANDOM) * 20 + 500;
      repeat (limit) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      op_t         op;
      logic [31:0] r;
      data_t       w;
      int          idle_wait;
      rst_n  = 1'b0;
      lsu_p  = '0;
      rs1    = '0;
      rs2    = '0;
      offset = '0;
      rng    = 32'd9;
      for (int i = 0; i < (1 << DCCM_WORD_BITS); i++) begin
         dccm_mem[i] = fill_word(i);
         touched[i]  = 1'b0;
         for (int b = 0; b < 4; b++) shadow[4*i + b] = dccm_mem[i][8*b +: 8];
      end
      build_table();
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      check("reset idle", 32'd1, 32'(lsu_idle));
      check("reset rden", 32'd0, 32'(dccm_rden));
      check("reset wren", 32'd0, 32'(dccm_wren));
      check("reset stall", 32'd0, 32'(lsu_store_stall));
      check("reset load_valid", 32'd0, 32'(lsu_load_valid_dc3));
      check("reset exc_valid", 32'd0, 32'(lsu_error_pkt_dc3.exc_valid));
      foreach (op_table[i]) issue_op(op_table[i]);
      // random ops, mostly over 16 dccm words
      for (int i = 0; i < N_RANDOM; i++) begin
         rng      = xorshift(rng);
         r        = rng;
         rng      = xorshift(rng);
         op.name  = $sformatf("rand%0d", i);
         op.st    = r[0];
         op.size  = int'(r[2:1]) % 3;
         op.uns   = r[3];
         op.rs1   = (r[11:8] == 4'h0) ? 32'h2000_0040 : DCCM_BASE + 32'h40;
         op.off   = {6'h0, r[7:4], (r[12] ? r[14:13] : 2'b00)};
         op.data  = rng;
         op.fault = fault_of(op.rs1 + {20'h0, op.off}, op.size);
         op.gap   = r[15] ? 0 : int'(r[17:16]);
         issue_op(op);
      end
      while (exp_name_q.size() != 0) @(negedge clk);
      // the buffer drains within a few cycles once no load is in flight
      idle_wait = 0;
      while (!lsu_idle && idle_wait < 4 * LSU_SB_DEPTH) begin
         @(negedge clk);
         idle_wait++;
      end
      check("final idle", 32'd1, 32'(lsu_idle));
      for (int i = 0; i < (1 << DCCM_WORD_BITS); i++) begin
         if (touched[i]) begin
            w = {shadow[4*i + 3], shadow[4*i + 2], shadow[4*i + 1], shadow[4*i]};
            check($sformatf("mem[%0d]", i), w, dccm_mem[i]);
         end
      end
      check("dccm reads", 32'(reads_exp), 32'(reads_seen));
      check("dccm writes", 32'(writes_exp), 32'(writes_seen));
      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: verilog/lsu.sv
`timescale 1ns/1ps

module lsu (
   input  logic                    clk,
   input  logic                    rst_n,

   input  lsu_pkg::lsu_pkt_t       lsu_p,
   input  lsu_pkg::data_t          exu_lsu_rs1_d,
   input  lsu_pkg::data_t          exu_lsu_rs2_d,
   input  logic [11:0]             dec_lsu_offset_d,

   output lsu_pkg::data_t          lsu_result_dc3,
   output logic                    lsu_load_valid_dc3,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic                    lsu_store_stall,
   output logic                    lsu_idle,

   output logic                    dccm_rden,
   output logic                    dccm_wren,
   output lsu_pkg::dccm_addr_t     dccm_addr,
   output lsu_pkg::data_t          dccm_wr_data,
   output lsu_pkg::byteen_t        dccm_wr_byteen,
   input  lsu_pkg::data_t          dccm_rd_data
);

   import lsu_pkg::*;

   lsu_pkt_t lsu_pkt_dc1;
   lsu_pkt_t lsu_pkt_dc2;
   addr_t    lsu_addr_dc1;
   addr_t    lsu_addr_dc2;
   lsu_stq_t store_stq_dc2;

   lsu_stq_t stbuf_drain;
   logic     stbuf_drain_ack;
   logic     stbuf_empty;
   data_t    stbuf_fwddata_dc2;
   byteen_t  stbuf_fwdbyteen_dc2;

   lsu_lsc_ctl lsc_ctl_i (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_p             (lsu_p),
      .exu_lsu_rs1_d     (exu_lsu_rs1_d),
      .exu_lsu_rs2_d     (exu_lsu_rs2_d),
      .dec_lsu_offset_d  (dec_lsu_offset_d),
      .stbuf_empty       (stbuf_empty),
      .lsu_pkt_dc1       (lsu_pkt_dc1),
      .lsu_pkt_dc2       (lsu_pkt_dc2),
      .lsu_addr_dc1      (lsu_addr_dc1),
      .lsu_addr_dc2      (lsu_addr_dc2),
      .store_stq_dc2     (store_stq_dc2),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3),
      .lsu_idle          (lsu_idle)
   );

   lsu_stbuf stbuf_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .lsu_pkt_dc1         (lsu_pkt_dc1),
      .lsu_pkt_dc2         (lsu_pkt_dc2),
      .lsu_addr_dc2        (lsu_addr_dc2),
      .store_stq_dc2       (store_stq_dc2),
      .stbuf_drain_ack     (stbuf_drain_ack),
      .stbuf_drain         (stbuf_drain),
      .stbuf_fwddata_dc2   (stbuf_fwddata_dc2),
      .stbuf_fwdbyteen_dc2 (stbuf_fwdbyteen_dc2),
      .stbuf_empty         (stbuf_empty),
      .lsu_store_stall     (lsu_store_stall)
   );

   lsu_dccm_ctl dccm_ctl_i (
      .clk                 (clk),
      .rst_n               (rst_n),
      .lsu_pkt_dc1         (lsu_pkt_dc1),
      .lsu_pkt_dc2         (lsu_pkt_dc2),
      .lsu_addr_dc1        (lsu_addr_dc1),
      .lsu_addr_dc2        (lsu_addr_dc2),
      .stbuf_drain         (stbuf_drain),
      .stbuf_fwddata_dc2   (stbuf_fwddata_dc2),
      .stbuf_fwdbyteen_dc2 (stbuf_fwdbyteen_dc2),
      .dccm_rd_data        (dccm_rd_data),
      .stbuf_drain_ack     (stbuf_drain_ack),
      .dccm_rden           (dccm_rden),
      .dccm_wren           (dccm_wren),
      .dccm_addr           (dccm_addr),
      .dccm_wr_data        (dccm_wr_data),
      .dccm_wr_byteen      (dccm_wr_byteen),
      .lsu_result_dc3      (lsu_result_dc3),
      .lsu_load_valid_dc3  (lsu_load_valid_dc3)
   );

endmodule

// File: verilog/lsu_dccm_ctl.sv
`timescale 1ns/1ps

module lsu_dccm_ctl (
   input  logic                clk,
   input  logic                rst_n,

   input  lsu_pkg::lsu_pkt_t   lsu_pkt_dc1,
   input  lsu_pkg::lsu_pkt_t   lsu_pkt_dc2,
   input  lsu_pkg::addr_t      lsu_addr_dc1,
   input  lsu_pkg::addr_t      lsu_addr_dc2,
   input  lsu_pkg::lsu_stq_t   stbuf_drain,
   input  lsu_pkg::data_t      stbuf_fwddata_dc2,
   input  lsu_pkg::byteen_t    stbuf_fwdbyteen_dc2,
   input  lsu_pkg::data_t      dccm_rd_data,

   output logic                stbuf_drain_ack,
   output logic                dccm_rden,
   output logic                dccm_wren,
   output lsu_pkg::dccm_addr_t dccm_addr,
   output lsu_pkg::data_t      dccm_wr_data,
   output lsu_pkg::byteen_t    dccm_wr_byteen,
   output lsu_pkg::data_t      lsu_result_dc3,
   output logic                lsu_load_valid_dc3
);

   import lsu_pkg::*;

   logic  ld_valid_dc2;
   data_t ld_merged_dc2;
   data_t ld_shifted_dc2;
   data_t ld_result_dc2;

   // single port, a load in dc1 always wins over the drain
   assign dccm_rden       = lsu_pkt_dc1.valid & lsu_pkt_dc1.load;
   assign dccm_wren       = stbuf_drain.valid & ~dccm_rden;
   assign stbuf_drain_ack = dccm_wren;

   assign dccm_addr      = dccm_rden ? lsu_addr_dc1[DCCM_BITS-1:2] : stbuf_drain.addr;
   assign dccm_wr_data   = stbuf_drain.data;
   assign dccm_wr_byteen = stbuf_drain.byteen;

   assign ld_valid_dc2 = lsu_pkt_dc2.valid & lsu_pkt_dc2.load;

   // buffered bytes are newer than the array
   always_comb begin
      for (int b = 0; b < DCCM_BYTE_WIDTH; b++) begin
         ld_merged_dc2[8*b +: 8] = stbuf_fwdbyteen_dc2[b] ? stbuf_fwddata_dc2[8*b +: 8]
                                                          : dccm_rd_data[8*b +: 8];
      end
   end

   assign ld_shifted_dc2 = ld_merged_dc2 >> {lsu_addr_dc2[1:0], 3'b000};

   always_comb begin
      if (lsu_pkt_dc2.by) begin
         ld_result_dc2 = {{24{~lsu_pkt_dc2.unsign & ld_shifted_dc2[7]}}, ld_shifted_dc2[7:0]};
      end else if (lsu_pkt_dc2.half) begin
         ld_result_dc2 = {{16{~lsu_pkt_dc2.unsign & ld_shifted_dc2[15]}},
                          ld_shifted_dc2[15:0]};
      end else begin
         ld_result_dc2 = ld_shifted_dc2;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lsu_load_valid_dc3 <= 1'b0;
      end else begin
         lsu_load_valid_dc3 <= ld_valid_dc2;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_valid_dc2) begin
         lsu_result_dc3 <= ld_result_dc2;
      end
   end

endmodule

// File: verilog/lsu_stbuf.sv
`timescale 1ns/1ps

module lsu_stbuf (
   input  logic              clk,
   input  logic              rst_n,

   input  lsu_pkg::lsu_pkt_t lsu_pkt_dc1,
   input  lsu_pkg::lsu_pkt_t lsu_pkt_dc2,
   input  lsu_pkg::addr_t    lsu_addr_dc2,
   input  lsu_pkg::lsu_stq_t store_stq_dc2,
   input  logic              stbuf_drain_ack,

   output lsu_pkg::lsu_stq_t stbuf_drain,
   output lsu_pkg::data_t    stbuf_fwddata_dc2,
   output lsu_pkg::byteen_t  stbuf_fwdbyteen_dc2,
   output logic              stbuf_empty,
   output logic              lsu_store_stall
);

   import lsu_pkg::*;

   lsu_stq_t                   sb_mem [LSU_SB_DEPTH];
   logic [LSU_SB_PTR_BITS-1:0] wr_ptr;
   logic [LSU_SB_PTR_BITS-1:0] rd_ptr;
   logic [LSU_SB_PTR_BITS:0]   sb_count;
   logic [LSU_SB_PTR_BITS+1:0] sb_inflight;
   logic                       sb_alloc;
   logic                       sb_retire;
   logic                       fwd_en_dc2;
   dccm_addr_t                 ld_waddr_dc2;

   assign sb_alloc  = store_stq_dc2.valid;
   assign sb_retire = stbuf_drain_ack;

   always_ff @(posedge clk) begin
      if (sb_alloc) begin
         sb_mem[wr_ptr] <= store_stq_dc2;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         sb_count <= '0;
      end else begin
         if (sb_alloc) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (sb_retire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({sb_alloc, sb_retire})
            2'b10:   sb_count <= sb_count + 1'b1;
            2'b01:   sb_count <= sb_count - 1'b1;
            default: sb_count <= sb_count;
         endcase
      end
   end

   assign stbuf_empty = (sb_count == '0);

   // oldest entry is offered to the dccm port
   always_comb begin
      stbuf_drain       = sb_mem[rd_ptr];
      stbuf_drain.valid = ~stbuf_empty;
   end

   assign fwd_en_dc2   = lsu_pkt_dc2.valid & lsu_pkt_dc2.load;
   assign ld_waddr_dc2 = lsu_addr_dc2[DCCM_BITS-1:2];

   // walk oldest to youngest so younger stores overwrite per byte
   always_comb begin
      logic [LSU_SB_PTR_BITS-1:0] idx;
      stbuf_fwddata_dc2   = '0;
      stbuf_fwdbyteen_dc2 = '0;
      idx                 = rd_ptr;
      for (int i = 0; i < LSU_SB_DEPTH; i++) begin
         idx = rd_ptr + LSU_SB_PTR_BITS'(i);
         if (fwd_en_dc2 && ((LSU_SB_PTR_BITS+1)'(i) < sb_count) &&
             (sb_mem[idx].addr == ld_waddr_dc2)) begin
            for (int b = 0; b < DCCM_BYTE_WIDTH; b++) begin
               if (sb_mem[idx].byteen[b]) begin
                  stbuf_fwddata_dc2[8*b +: 8] = sb_mem[idx].data[8*b +: 8];
                  stbuf_fwdbyteen_dc2[b]      = 1'b1;
               end
            end
         end
      end
   end

   // stores already past the stall check still need a slot
   assign sb_inflight = (LSU_SB_PTR_BITS+2)'(sb_count) +
                        (LSU_SB_PTR_BITS+2)'(lsu_pkt_dc1.valid & lsu_pkt_dc1.store) +
                        (LSU_SB_PTR_BITS+2)'(lsu_pkt_dc2.valid & lsu_pkt_dc2.store);

   assign lsu_store_stall = (sb_inflight >= (LSU_SB_PTR_BITS+2)'(LSU_SB_DEPTH));

endmodule

// File: verilog/lsu_lsc_ctl.sv
`timescale 1ns/1ps

module lsu_lsc_ctl (
   input  logic                    clk,
   input  logic                    rst_n,

   input  lsu_pkg::lsu_pkt_t       lsu_p,
   input  lsu_pkg::data_t          exu_lsu_rs1_d,
   input  lsu_pkg::data_t          exu_lsu_rs2_d,
   input  logic [11:0]             dec_lsu_offset_d,
   input  logic                    stbuf_empty,

   output lsu_pkg::lsu_pkt_t       lsu_pkt_dc1,
   output lsu_pkg::lsu_pkt_t       lsu_pkt_dc2,
   output lsu_pkg::addr_t          lsu_addr_dc1,
   output lsu_pkg::addr_t          lsu_addr_dc2,
   output lsu_pkg::lsu_stq_t       store_stq_dc2,
   output lsu_pkg::lsu_error_pkt_t lsu_error_pkt_dc3,
   output logic                    lsu_idle
);

   import lsu_pkg::*;

   lsu_pkt_t       lsu_pkt_dc1_pre;
   addr_t          lsu_addr_d;
   data_t          store_data_dc1;
   data_t          store_data_dc2;
   logic           addr_in_dccm_dc1;
   logic           misaligned_dc1;
   logic           ldst_dc1;
   lsu_error_pkt_t error_pkt_dc1;
   lsu_error_pkt_t error_pkt_dc2;
   byteen_t        size_byteen_dc2;

   // base plus sign-extended 12-bit offset
   assign lsu_addr_d = exu_lsu_rs1_d + {{20{dec_lsu_offset_d[11]}}, dec_lsu_offset_d};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lsu_pkt_dc1_pre <= '0;
      end else begin
         lsu_pkt_dc1_pre <= lsu_p;
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_p.valid) begin
         lsu_addr_dc1   <= lsu_addr_d;
         store_data_dc1 <= exu_lsu_rs2_d;
      end
   end

   // region and alignment checks
   assign addr_in_dccm_dc1 = (lsu_addr_dc1[31:DCCM_BITS] == DCCM_BASE[31:DCCM_BITS]);
   assign misaligned_dc1   = (lsu_pkt_dc1_pre.half & lsu_addr_dc1[0]) |
                             (lsu_pkt_dc1_pre.word & (|lsu_addr_dc1[1:0]));
   assign ldst_dc1         = lsu_pkt_dc1_pre.valid & (lsu_pkt_dc1_pre.load | lsu_pkt_dc1_pre.store);

   always_comb begin
      error_pkt_dc1.exc_valid = ldst_dc1 & (misaligned_dc1 | ~addr_in_dccm_dc1);
      error_pkt_dc1.is_store  = lsu_pkt_dc1_pre.store;
      error_pkt_dc1.addr      = lsu_addr_dc1;
      if (misaligned_dc1) begin
         error_pkt_dc1.mscause = FAULT_MISALIGNED;
      end else if (!addr_in_dccm_dc1) begin
         error_pkt_dc1.mscause = FAULT_ACCESS;
      end else begin
         error_pkt_dc1.mscause = FAULT_NONE;
      end
   end

   // a faulting op goes no further down the pipe
   always_comb begin
      lsu_pkt_dc1       = lsu_pkt_dc1_pre;
      lsu_pkt_dc1.valid = ldst_dc1 & ~error_pkt_dc1.exc_valid;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lsu_pkt_dc2       <= '0;
         error_pkt_dc2     <= '0;
         lsu_error_pkt_dc3 <= '0;
      end else begin
         lsu_pkt_dc2       <= lsu_pkt_dc1;
         error_pkt_dc2     <= error_pkt_dc1;
         lsu_error_pkt_dc3 <= error_pkt_dc2;
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_pkt_dc1_pre.valid) begin
         lsu_addr_dc2   <= lsu_addr_dc1;
         store_data_dc2 <= store_data_dc1;
      end
   end

   always_comb begin
      if (lsu_pkt_dc2.word) begin
         size_byteen_dc2 = '1;
      end else if (lsu_pkt_dc2.half) begin
         size_byteen_dc2 = byteen_t'(2'b11);
      end else begin
         size_byteen_dc2 = byteen_t'(1'b1);
      end
   end

   // store entry with bytes moved onto their lanes
   always_comb begin
      store_stq_dc2.valid  = lsu_pkt_dc2.valid & lsu_pkt_dc2.store;
      store_stq_dc2.addr   = lsu_addr_dc2[DCCM_BITS-1:2];
      store_stq_dc2.byteen = size_byteen_dc2 << lsu_addr_dc2[1:0];
      store_stq_dc2.data   = store_data_dc2 << {lsu_addr_dc2[1:0], 3'b000};
   end

   // faulting ops still count as busy until their error is reported
   assign lsu_idle = ~(lsu_pkt_dc1_pre.valid | lsu_pkt_dc2.valid | error_pkt_dc2.exc_valid) &
                     stbuf_empty;

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

   // dccm placement and geometry
   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;
   localparam int DCCM_BITS = 16;
   localparam int DCCM_WORD_BITS = DCCM_BITS - 2;
   localparam int DCCM_BYTE_WIDTH = 4;

   // store buffer sizing
   localparam int LSU_SB_DEPTH = 4;
   localparam int LSU_SB_PTR_BITS = $clog2(LSU_SB_DEPTH);

   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [DCCM_WORD_BITS-1:0] dccm_addr_t;
   typedef logic [DCCM_BYTE_WIDTH-1:0] byteen_t;

   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic by;
      logic half;
      logic word;
      logic unsign;
   } lsu_pkt_t;

   typedef enum logic [1:0] {
      FAULT_NONE       = 2'd0,
      FAULT_MISALIGNED = 2'd1,
      FAULT_ACCESS     = 2'd2
   } lsu_fault_e;

   typedef struct packed {
      logic       exc_valid;
      logic       is_store;
      lsu_fault_e mscause;
      addr_t      addr;
   } lsu_error_pkt_t;

   // one store buffer write, data already on its byte lanes
   typedef struct packed {
      logic       valid;
      dccm_addr_t addr;
      byteen_t    byteen;
      data_t      data;
   } lsu_stq_t;

endpackage
